//--- vlog.f
+incdir+.
edge_pkg.sv
read_path.sv
write_heap.sv
write_beat_expand.sv
mem_edge.sv
mem_edge_chk.sv
tb_mem_edge.sv

//--- Makefile
# Verilator build and run of the memory edge testbench
SIM_DIR = obj_dir
LOG = sim.log

.PHONY: help test clean

help:
	@echo "make test   build with Verilator, run the testbench and check the log"
	@echo "make clean  remove the build directory and the log"

test:
	verilator --binary --timing --assert --top-module tb_mem_edge -f vlog.f --Mdir $(SIM_DIR) -o tb_mem_edge
	./$(SIM_DIR)/tb_mem_edge > $(LOG) 2>&1; cat $(LOG)
	grep -q "Test completed successfully" $(LOG)

clean:
	rm -rf $(SIM_DIR) $(LOG)

//--- tb_mem_edge.sv
// Testbench for the memory edge; runs read, walker and write tables against a memory-port model
`timescale 1ns/1ps
`include "edge_macros.svh"

module tb_mem_edge
    import edge_pkg::*;
();

    localparam int NUM_WR = 6;
    localparam int NUM_RD = 3;
    // Every applied row gets 40 cycles; the write table runs twice
    localparam int TIMEOUT_CYCLES = 40 * (2 * NUM_WR + NUM_RD) + 200;

    // Write row columns are heap slot, beats minus one, line address and data seed
    typedef struct packed {
        heap_idx_t   idx;
        cl_num_t     len;
        addr_t       addr;
        logic [31:0] seed;
    } wr_row_t;

    // Read row columns are address, accelerator mdata and the response tag bit
    typedef struct packed {
        addr_t  addr;
        mdata_t mdata;
        logic   tag;
    } rd_row_t;

    // Expected memory-port beat and expected slot release
    typedef struct packed {
        logic [7:0]  row_num;
        logic        timed;
        logic [31:0] cycle;
        logic        sop;
        addr_t       addr;
        line_t       data;
    } exp_beat_t;

    typedef struct packed {
        logic [7:0]  row_num;
        logic        timed;
        logic [31:0] cycle;
        heap_idx_t   idx;
    } exp_free_t;

    // ====================
    // Test tables
    // ====================

    // Slots are all distinct so that no heap write lands on a slot still being read
    wr_row_t wr_table [NUM_WR] = '{
        '{idx: 4'd3,  len: 2'd0, addr: 32'h0000_1000, seed: 32'h1357_9bdf},
        '{idx: 4'd7,  len: 2'd1, addr: 32'h0000_2040, seed: 32'h2468_ace0},
        '{idx: 4'd12, len: 2'd3, addr: 32'h0001_0100, seed: 32'hcafe_0001},
        '{idx: 4'd0,  len: 2'd2, addr: 32'hfff0_0008, seed: 32'h0bad_f00d},
        '{idx: 4'd15, len: 2'd3, addr: 32'h8000_0ffc, seed: 32'h7777_1234},
        '{idx: 4'd9,  len: 2'd3, addr: 32'h0000_3001, seed: 32'h5a5a_a5a5}
    };
    string wr_names [NUM_WR] = '{"wr_one_line", "wr_two_lines", "wr_four_lines",
                                 "wr_three_lines", "wr_four_lines_top", "wr_odd_addr"};

    rd_row_t rd_table [NUM_RD] = '{
        '{addr: 32'h0000_4000, mdata: 16'h0001, tag: 1'b0},
        '{addr: 32'h1234_5678, mdata: 16'h7fff, tag: 1'b1},
        '{addr: 32'hdead_bee0, mdata: 16'h4abc, tag: 1'b0}
    };
    string rd_names [NUM_RD] = '{"rd_plain", "rd_walker_tag", "rd_high_mdata"};

    // ====================
    // DUT and clocking
    // ====================

    logic      clk = 1'b0;
    logic      reset;
    c0_req_t   afu_c0_tx;
    logic      afu_c0_alm_full;
    c0_rsp_t   afu_c0_rx;
    c1_req_t   afu_c1_tx;
    logic      afu_c1_alm_full;
    heap_wr_t  heap_wr;
    logic      heap_free;
    heap_idx_t heap_free_idx;
    logic      pt_read_en;
    addr_t     pt_read_addr;
    logic      pt_read_rdy;
    logic      pt_data_en;
    line_t     pt_data;
    c0_req_t   fiu_c0_tx;
    logic      fiu_c0_alm_full;
    c0_rsp_t   fiu_c0_rx;
    c1_tx_t    fiu_c1_tx;
    logic      fiu_c1_alm_full = 1'b0;

    int          cycle = 0;
    int          read_errors = 0;
    int          write_errors = 0;
    int          free_errors = 0;
    integer      seed = 75119;
    logic [31:0] bp_draw;
    logic        bp_phase = 1'b0;
    exp_beat_t   beat_q [$];
    exp_free_t   free_q [$];
    exp_beat_t   beat_exp;
    exp_free_t   free_exp;

    // Cycles in which stage 1 still has beats of the latest timed row to issue
    int          busy_from = 0;
    int          busy_until = 0;
    string       busy_name = "wr_idle";

    mem_edge u_dut (.*);

    always #50 clk = ~clk;

    always @(posedge clk)
    begin
        cycle <= cycle + 1;
        if (cycle >= TIMEOUT_CYCLES)
        begin
            $display("Timeout: tests still running after %0d cycles", cycle);
            $display("Test failed");
            $finish;
        end
    end

    // Memory-port write back-pressure, random only in the back-pressure phase
    always @(posedge clk)
    begin
        #1;
        bp_draw = $random(seed);
        fiu_c1_alm_full = bp_phase && bp_draw[0];
    end

    // ====================
    // Helpers
    // ====================

    // Line written to the heap for one beat of a row
    function automatic line_t line_value(input logic [31:0] row_seed, input cl_num_t beat);
        line_value = {row_seed + {30'd0, beat}, ~row_seed ^ {30'd0, beat}};
    endfunction

    // Returns one on a mismatch, after reporting it
    function automatic int compare_field(input string test, input string field,
                                         input logic [127:0] exp_val,
                                         input logic [127:0] act_val);
        compare_field = 0;
        assert (act_val === exp_val)
        else
        begin
            $display("error %s: %s expected %0h actual %0h", test, field, exp_val, act_val);
            compare_field = 1;
        end
    endfunction

    task automatic run_read_row(input int r);
        rd_row_t row;
        c0_req_t exp_req;
        c0_rsp_t rsp;
        string   name;
        row = rd_table[r];
        name = rd_names[r];

        // Accelerator read with the walker idle passes through in the same cycle
        @(posedge clk);
        #1;
        afu_c0_tx = '{valid: 1'b1, addr: row.addr, mdata: row.mdata};
        exp_req = '{valid: 1'b1, addr: row.addr, mdata: row.mdata};
        @(negedge clk);
        read_errors += compare_field(name, "fiu_c0_tx", 128'(exp_req), 128'(fiu_c0_tx));

        // Walker request lands while the memory port is back-pressured
        @(posedge clk);
        #1;
        afu_c0_tx = '0;
        fiu_c0_alm_full = 1'b1;
        pt_read_en = 1'b1;
        pt_read_addr = row.addr;
        @(posedge clk);
        #1;
        pt_read_en = 1'b0;
        repeat (2)
        begin
            @(negedge clk);
            read_errors += compare_field(name, "afu_c0_alm_full", 128'(1), 128'(afu_c0_alm_full));
            read_errors += compare_field(name, "pt_read_rdy", 128'(0), 128'(pt_read_rdy));
            read_errors += compare_field(name, "fiu_c0_tx.valid", 128'(0), 128'(fiu_c0_tx.valid));
            @(posedge clk);
            #1;
        end

        // Port frees up and the walker read goes out exactly once with only the tag
        fiu_c0_alm_full = 1'b0;
        exp_req = '{valid: 1'b1, addr: row.addr, mdata: mdata_t'(1) << `RESERVED_MDATA_IDX};
        @(negedge clk);
        read_errors += compare_field(name, "walker fiu_c0_tx", 128'(exp_req), 128'(fiu_c0_tx));
        read_errors += compare_field(name, "pt_read_rdy", 128'(0), 128'(pt_read_rdy));
        @(negedge clk);
        read_errors += compare_field(name, "fiu_c0_tx.valid", 128'(0), 128'(fiu_c0_tx.valid));
        read_errors += compare_field(name, "pt_read_rdy", 128'(1), 128'(pt_read_rdy));
        read_errors += compare_field(name, "afu_c0_alm_full", 128'(0), 128'(afu_c0_alm_full));

        // Response steering by the tag bit
        @(posedge clk);
        #1;
        rsp = '{valid: 1'b1, mdata: row.mdata | (mdata_t'(row.tag) << `RESERVED_MDATA_IDX),
                data: {row.addr, ~row.addr}};
        fiu_c0_rx = rsp;
        @(negedge clk);
        if (row.tag)
        begin
            read_errors += compare_field(name, "pt_data_en", 128'(1), 128'(pt_data_en));
            read_errors += compare_field(name, "pt_data", 128'(rsp.data), 128'(pt_data));
            read_errors += compare_field(name, "afu_c0_rx.valid", 128'(0), 128'(afu_c0_rx.valid));
        end
        else
        begin
            read_errors += compare_field(name, "pt_data_en", 128'(0), 128'(pt_data_en));
            read_errors += compare_field(name, "afu_c0_rx", 128'(rsp), 128'(afu_c0_rx));
        end
        @(posedge clk);
        #1;
        fiu_c0_rx = '0;
    endtask

    task automatic run_write_row(input int r, input bit timed);
        wr_row_t   row;
        exp_beat_t eb;
        exp_free_t ef;
        int        acc;
        row = wr_table[r];

        // Heap data for every beat goes in ahead of the request
        for (int k = 0; k <= int'(row.len); k++)
        begin
            @(posedge clk);
            #1;
            heap_wr = '{en: 1'b1, idx: row.idx, cl_num: cl_num_t'(k),
                        data: line_value(row.seed, cl_num_t'(k))};
        end
        @(posedge clk);
        #1;
        heap_wr = '0;
        afu_c1_tx = '{valid: 1'b1, addr: row.addr, len: row.len, idx: row.idx};

        // The request is taken on the first edge with afu_c1_alm_full low
        @(negedge clk);
        while (afu_c1_alm_full)
        begin
            @(negedge clk);
        end
        acc = cycle + 1;

        // Beat k leaves two cycles after acceptance plus k
        for (int k = 0; k <= int'(row.len); k++)
        begin
            eb = '{row_num: 8'(r), timed: timed, cycle: 32'(acc + 2 + k), sop: (k == 0),
                   addr: row.addr | addr_t'(k), data: line_value(row.seed, cl_num_t'(k))};
            beat_q.push_back(eb);
        end
        // Slot frees one cycle after the last beat leaves stage 1
        ef = '{row_num: 8'(r), timed: timed, cycle: 32'(acc + int'(row.len) + 1), idx: row.idx};
        free_q.push_back(ef);

        @(posedge clk);
        #1;
        afu_c1_tx = '0;

        // Stage 1 has beats left to issue from the acceptance edge until its last beat
        if (timed)
        begin
            busy_name = wr_names[r];
            busy_from = acc;
            busy_until = acc + int'(row.len);
        end
    endtask

    task automatic wait_drained();
        while (beat_q.size() != 0 || free_q.size() != 0)
        begin
            @(negedge clk);
        end
    endtask

    // ====================
    // Memory-port model
    // ====================

    always @(negedge clk)
    begin
        if (!reset && fiu_c1_tx.valid)
        begin
            assert (beat_q.size() != 0)
            else
            begin
                $display("Write beat on the memory port with no request outstanding");
                write_errors++;
            end
            if (beat_q.size() != 0)
            begin
                beat_exp = beat_q.pop_front();
                write_errors += compare_field(wr_names[beat_exp.row_num], "sop",
                                              128'(beat_exp.sop), 128'(fiu_c1_tx.sop));
                write_errors += compare_field(wr_names[beat_exp.row_num], "addr",
                                              128'(beat_exp.addr), 128'(fiu_c1_tx.addr));
                write_errors += compare_field(wr_names[beat_exp.row_num], "data",
                                              128'(beat_exp.data), 128'(fiu_c1_tx.data));
                if (beat_exp.timed)
                begin
                    write_errors += compare_field(wr_names[beat_exp.row_num], "beat cycle",
                                                  128'(beat_exp.cycle), 128'(cycle));
                end
            end
        end
    end

    always @(negedge clk)
    begin
        if (!reset && heap_free)
        begin
            assert (free_q.size() != 0)
            else
            begin
                $display("heap_free pulsed with no slot waiting to be released");
                free_errors++;
            end
            if (free_q.size() != 0)
            begin
                free_exp = free_q.pop_front();
                free_errors += compare_field(wr_names[free_exp.row_num], "heap_free_idx",
                                             128'(free_exp.idx), 128'(heap_free_idx));
                if (free_exp.timed)
                begin
                    free_errors += compare_field(wr_names[free_exp.row_num], "free cycle",
                                                 128'(free_exp.cycle), 128'(cycle));
                end
            end
        end
    end

    // Writes are refused while the port is back-pressured or a request still has beats left
    always @(negedge clk)
    begin
        if (!reset && !bp_phase)
        begin
            write_errors += compare_field(busy_name, "afu_c1_alm_full",
                128'(fiu_c1_alm_full || (cycle >= busy_from && cycle < busy_until)),
                128'(afu_c1_alm_full));
        end
    end

    // ====================
    // Main sequence
    // ====================

    initial
    begin
        reset = 1'b1;
        afu_c0_tx = '0;
        afu_c1_tx = '0;
        heap_wr = '0;
        pt_read_en = 1'b0;
        pt_read_addr = '0;
        fiu_c0_alm_full = 1'b0;
        fiu_c0_rx = '0;
        repeat (10) @(posedge clk);
        #1;
        reset = 1'b0;
        @(negedge clk);
        read_errors += compare_field("reset", "pt_read_rdy", 128'(1), 128'(pt_read_rdy));
        read_errors += compare_field("reset", "fiu_c0_tx.valid", 128'(0), 128'(fiu_c0_tx.valid));

        for (int r = 0; r < NUM_RD; r++)
        begin
            run_read_row(r);
        end

        // Writes with the memory port always ready, timing checked
        for (int r = 0; r < NUM_WR; r++)
        begin
            run_write_row(r, 1'b1);
        end
        wait_drained();

        // Same rows under random back-pressure, order and content only
        bp_phase = 1'b1;
        for (int r = 0; r < NUM_WR; r++)
        begin
            run_write_row(r, 1'b0);
        end
        wait_drained();
        bp_phase = 1'b0;
        repeat (4) @(negedge clk);

        $display("Errors: read %0d, write %0d, free %0d", read_errors, write_errors, free_errors);
        if (read_errors + write_errors + free_errors == 0)
        begin
            $display("Test completed successfully");
        end
        else
        begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

//--- mem_edge_chk.sv
// Concurrent checks on the memory edge ports, bound into every mem_edge instance
`timescale 1ns/1ps
`include "edge_macros.svh"

module mem_edge_chk
    import edge_pkg::*;
(
    input logic    clk,
    input logic    reset,
    input c0_req_t afu_c0_tx,
    input c1_req_t afu_c1_tx,
    input logic    afu_c1_alm_full,
    input logic    heap_free,
    input c1_tx_t  fiu_c1_tx
);

    // ====================
    // Beat framing model
    // ====================

    // Lengths of accepted writes, consumed in order as each sop beat leaves
    cl_num_t    len_fifo [0:3];
    logic [1:0] wr_ptr;
    logic [1:0] rd_ptr;
    cl_num_t    cur_len;
    // Beats of the current request seen so far; zero only before the first beat
    logic [2:0] sent;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            cur_len <= '0;
            sent <= '0;
        end
        else
        begin
            if (afu_c1_tx.valid && !afu_c1_alm_full)
            begin
                len_fifo[wr_ptr] <= afu_c1_tx.len;
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (fiu_c1_tx.valid)
            begin
                if (fiu_c1_tx.sop)
                begin
                    cur_len <= len_fifo[rd_ptr];
                    rd_ptr <= rd_ptr + 1'b1;
                    sent <= 3'd1;
                end
                else
                begin
                    sent <= sent + 1'b1;
                end
            end
        end
    end

    // ====================
    // Assertions
    // ====================

    // Walker tags must never come from the accelerator
    a_acc_no_reserved: assert property (@(posedge clk) disable iff (reset)
        afu_c0_tx.valid |-> !afu_c0_tx.mdata[`RESERVED_MDATA_IDX])
        else $error("Accelerator read carries the reserved metadata bit");

    // One pulse per freed slot
    a_free_single: assert property (@(posedge clk) disable iff (reset)
        heap_free |=> !heap_free)
        else $error("heap_free stayed high for two cycles");

    // A new request starts only after all beats of the previous one
    a_sop_framing: assert property (@(posedge clk) disable iff (reset)
        (fiu_c1_tx.valid && fiu_c1_tx.sop) |-> (sent == '0 || sent == {1'b0, cur_len} + 3'd1))
        else $error("Write sop arrived before the previous request completed");

    // Continuation beats never run past the request length
    a_beat_bound: assert property (@(posedge clk) disable iff (reset)
        (fiu_c1_tx.valid && !fiu_c1_tx.sop) |-> (sent != '0 && sent <= {1'b0, cur_len}))
        else $error("Write beat without sop outside of a request");

endmodule

bind mem_edge mem_edge_chk u_chk (
    .clk             (clk),
    .reset           (reset),
    .afu_c0_tx       (afu_c0_tx),
    .afu_c1_tx       (afu_c1_tx),
    .afu_c1_alm_full (afu_c1_alm_full),
    .heap_free       (heap_free),
    .fiu_c1_tx       (fiu_c1_tx)
);

//--- mem_edge.sv
// Top level of the memory-side request edge; connects the accelerator and walker to the memory port
`timescale 1ns/1ps

module mem_edge
    import edge_pkg::*;
(
    input  logic      clk,
    input  logic      reset,

    // Accelerator side
    input  c0_req_t   afu_c0_tx,
    output logic      afu_c0_alm_full,
    output c0_rsp_t   afu_c0_rx,
    input  c1_req_t   afu_c1_tx,
    output logic      afu_c1_alm_full,
    input  heap_wr_t  heap_wr,
    output logic      heap_free,
    output heap_idx_t heap_free_idx,

    // Page-table walker side
    input  logic      pt_read_en,
    input  addr_t     pt_read_addr,
    output logic      pt_read_rdy,
    output logic      pt_data_en,
    output line_t     pt_data,

    // Memory port
    output c0_req_t   fiu_c0_tx,
    input  logic      fiu_c0_alm_full,
    input  c0_rsp_t   fiu_c0_rx,
    output c1_tx_t    fiu_c1_tx,
    input  logic      fiu_c1_alm_full
);

    // Heap traffic between the write expander and the heap RAM
    heap_addr_t heap_raddr;
    line_t      heap_rdata;
    logic       free_en;
    heap_idx_t  free_idx;

    // ====================
    // Read channel
    // ====================

    // Walker injection and response steering live together
    read_path u_read_path (
        .clk             (clk),
        .reset           (reset),
        .afu_c0_tx       (afu_c0_tx),
        .fiu_c0_alm_full (fiu_c0_alm_full),
        .fiu_c0_rx       (fiu_c0_rx),
        .pt_read_en      (pt_read_en),
        .pt_read_addr    (pt_read_addr),
        .afu_c0_alm_full (afu_c0_alm_full),
        .fiu_c0_tx       (fiu_c0_tx),
        .afu_c0_rx       (afu_c0_rx),
        .pt_read_rdy     (pt_read_rdy),
        .pt_data_en      (pt_data_en),
        .pt_data         (pt_data)
    );

    // ====================
    // Write channel
    // ====================

    // The expander reads the heap two cycles ahead of each beat and merges the data on output
    write_beat_expand u_write_beat_expand (
        .clk             (clk),
        .reset           (reset),
        .afu_c1_tx       (afu_c1_tx),
        .fiu_c1_alm_full (fiu_c1_alm_full),
        .heap_rdata      (heap_rdata),
        .afu_c1_alm_full (afu_c1_alm_full),
        .heap_raddr      (heap_raddr),
        .free_en         (free_en),
        .free_idx        (free_idx),
        .fiu_c1_tx       (fiu_c1_tx)
    );

    write_heap u_write_heap (
        .clk           (clk),
        .reset         (reset),
        .heap_wr       (heap_wr),
        .raddr         (heap_raddr),
        .free_en       (free_en),
        .free_idx      (free_idx),
        .rdata         (heap_rdata),
        .heap_free     (heap_free),
        .heap_free_idx (heap_free_idx)
    );

endmodule

//--- write_beat_expand.sv
// Write channel of the memory edge; expands multi-line writes into one memory-port beat per line
`timescale 1ns/1ps

module write_beat_expand
    import edge_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  c1_req_t    afu_c1_tx,
    input  logic       fiu_c1_alm_full,
    input  line_t      heap_rdata,
    output logic       afu_c1_alm_full,
    output heap_addr_t heap_raddr,
    output logic       free_en,
    output heap_idx_t  free_idx,
    output c1_tx_t     fiu_c1_tx
);

    // Beat header carried alongside the heap read latency
    typedef struct packed {
        logic  valid;
        logic  sop;
        addr_t addr;
    } beat_hdr_t;

    // ====================
    // Stage 1
    // ====================

    // Current request and the position within it
    c1_req_t stg1_req;
    cl_num_t stg1_beat_idx;
    cl_num_t stg1_beats_rem;
    logic    stg1_sop;
    logic    stg1_blocked;
    logic    stg1_done;
    logic    accept;

    // The last beat leaves stage 1 on any cycle the port is not back-pressured
    assign stg1_done = (stg1_beats_rem == '0) && !fiu_c1_alm_full;

    // A new request can only follow once the current one is on its last beat
    assign afu_c1_alm_full = fiu_c1_alm_full || (stg1_req.valid && (stg1_beats_rem != '0));
    assign accept = afu_c1_tx.valid && !afu_c1_alm_full;

    // Release the heap slot as the last beat moves on
    assign free_en = stg1_done && stg1_req.valid;
    assign free_idx = stg1_req.idx;

    // Heap line of the beat now in stage 1
    assign heap_raddr = {stg1_req.idx, stg1_beat_idx};

    always_ff @(posedge clk)
    begin
        // Registered so that stage 2 sees a held beat only once
        stg1_blocked <= fiu_c1_alm_full;

        if (!fiu_c1_alm_full)
        begin
            if (accept)
            begin
                stg1_req <= afu_c1_tx;
                stg1_sop <= 1'b1;
                stg1_beat_idx <= '0;
                stg1_beats_rem <= afu_c1_tx.len;
            end
            else if (stg1_done)
            begin
                // Pipeline moves on with nothing new to take
                stg1_req.valid <= 1'b0;
            end
            else if (stg1_req.valid)
            begin
                // Step to the next beat of a multi-line write
                stg1_sop <= 1'b0;
                stg1_beat_idx <= stg1_beat_idx + 1'b1;
                stg1_beats_rem <= stg1_beats_rem - 1'b1;
            end
        end

        if (reset)
        begin
            stg1_req.valid <= 1'b0;
            stg1_sop <= 1'b0;
            stg1_beat_idx <= '0;
            stg1_beats_rem <= '0;
            stg1_blocked <= 1'b0;
        end
    end

    // ====================
    // Stages 2 and 3
    // ====================

    beat_hdr_t stg2_hdr;
    beat_hdr_t stg3_hdr;

    always_ff @(posedge clk)
    begin
        // A beat held in stage 1 produces an empty slot here after its first pass
        stg2_hdr.valid <= stg1_req.valid && !stg1_blocked;
        stg2_hdr.sop <= stg1_sop;
        // Low address bits of a line-aligned request select the beat
        stg2_hdr.addr <= stg1_req.addr | addr_t'(stg1_beat_idx);

        // One more stage to line up with the heap output register
        stg3_hdr <= stg2_hdr;

        if (reset)
        begin
            stg2_hdr.valid <= 1'b0;
            stg3_hdr.valid <= 1'b0;
        end
    end

    // Merge the header with its heap data on the way out
    assign fiu_c1_tx.valid = stg3_hdr.valid;
    assign fiu_c1_tx.sop = stg3_hdr.sop;
    assign fiu_c1_tx.addr = stg3_hdr.addr;
    assign fiu_c1_tx.data = heap_rdata;

endmodule

//--- write_heap.sv
// Write data heap of the memory edge; stores lines by slot and beat and reports freed slots
`timescale 1ns/1ps
`include "edge_macros.svh"

module write_heap
    import edge_pkg::*;
(
    input  logic       clk,
    input  logic       reset,
    input  heap_wr_t   heap_wr,
    input  heap_addr_t raddr,
    input  logic       free_en,
    input  heap_idx_t  free_idx,
    output line_t      rdata,
    output logic       heap_free,
    output heap_idx_t  heap_free_idx
);

    // One line per beat of every slot
    line_t heap_ram [0:`HEAP_ENTRIES*`MAX_BEATS-1];

    // ====================
    // Write port
    // ====================

    // The incoming write is registered before it reaches the RAM
    logic       wen;
    heap_addr_t waddr;
    line_t      wdata;

    always_ff @(posedge clk)
    begin
        wen <= heap_wr.en;
        waddr <= {heap_wr.idx, heap_wr.cl_num};
        wdata <= heap_wr.data;

        if (reset)
        begin
            wen <= 1'b0;
        end
    end

    always_ff @(posedge clk)
    begin
        if (wen)
        begin
            heap_ram[waddr] <= wdata;
        end
    end

    // ====================
    // Read port
    // ====================

    // Address register, then output register
    // Data lands two cycles after the address is presented
    heap_addr_t raddr_q;
    line_t      rdata_q;

    always_ff @(posedge clk)
    begin
        raddr_q <= raddr;
        rdata_q <= heap_ram[raddr_q];
    end

    assign rdata = rdata_q;

    // Freed slot goes back to the accelerator edge one cycle after the last beat
    always_ff @(posedge clk)
    begin
        heap_free <= free_en;
        heap_free_idx <= free_idx;

        if (reset)
        begin
            heap_free <= 1'b0;
        end
    end

endmodule

//--- read_path.sv
// Read channel of the memory edge; injects walker reads and steers read responses by metadata
`timescale 1ns/1ps
`include "edge_macros.svh"

module read_path
    import edge_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  c0_req_t afu_c0_tx,
    input  logic    fiu_c0_alm_full,
    input  c0_rsp_t fiu_c0_rx,
    input  logic    pt_read_en,
    input  addr_t   pt_read_addr,
    output logic    afu_c0_alm_full,
    output c0_req_t fiu_c0_tx,
    output c0_rsp_t afu_c0_rx,
    output logic    pt_read_rdy,
    output logic    pt_data_en,
    output line_t   pt_data
);

    // ====================
    // Walker request tracking
    // ====================

    // Only one walker read is outstanding at a time
    logic    pt_pending;
    logic    pt_emit;
    addr_t   pt_addr;
    c0_req_t pt_req;

    // The walker read goes out on the first cycle the memory port can take it
    assign pt_emit = pt_pending && !fiu_c0_alm_full;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            pt_pending <= 1'b0;
        end
        else
        begin
            // An emit clears the flag and a new request sets it, possibly both at once
            pt_pending <= (pt_pending ^ pt_emit) || pt_read_en;
        end

        // Address is payload and is only captured with the request
        if (pt_read_en)
        begin
            pt_addr <= pt_read_addr;
        end
    end

    // The walker may ask again once its read has left
    assign pt_read_rdy = !pt_pending;

    // Hold the accelerator off while a walker read waits for its slot
    assign afu_c0_alm_full = pt_pending || fiu_c0_alm_full;

    // ====================
    // Request arbitration
    // ====================

    always_comb
    begin
        // Walker reads carry only the reserved tag in their metadata
        pt_req.valid = 1'b1;
        pt_req.addr = pt_addr;
        pt_req.mdata = '0;
        pt_req.mdata[`RESERVED_MDATA_IDX] = 1'b1;

        // The walker wins; accelerator reads are held off by alm_full in that cycle
        if (pt_emit)
        begin
            fiu_c0_tx = pt_req;
        end
        else
        begin
            fiu_c0_tx = afu_c0_tx;
        end
    end

    // ====================
    // Response steering
    // ====================

    logic is_pt_rsp;

    // The reserved bit is never set on accelerator reads, so it marks walker data
    assign is_pt_rsp = fiu_c0_rx.mdata[`RESERVED_MDATA_IDX];

    assign pt_data_en = fiu_c0_rx.valid && is_pt_rsp;
    assign pt_data = fiu_c0_rx.data;

    always_comb
    begin
        afu_c0_rx = fiu_c0_rx;
        // Walker responses never reach the accelerator
        afu_c0_rx.valid = fiu_c0_rx.valid && !is_pt_rsp;
    end

endmodule

//--- edge_pkg.sv
// Types and request structs shared by every module of the memory edge; import with edge_pkg::*
`include "edge_macros.svh"

package edge_pkg;

    // Basic widths of the line and request fields
    typedef logic [`LINE_BITS-1:0]  line_t;
    typedef logic [`ADDR_BITS-1:0]  addr_t;
    typedef logic [`MDATA_BITS-1:0] mdata_t;

    // A heap slot covers all beats of one write request
    typedef logic [$clog2(`HEAP_ENTRIES)-1:0] heap_idx_t;
    typedef logic [$clog2(`MAX_BEATS)-1:0]    cl_num_t;

    // Slot and beat number together address one line in the heap RAM
    typedef logic [$bits(heap_idx_t)+$bits(cl_num_t)-1:0] heap_addr_t;

    // Read request toward memory, from either the accelerator or the walker
    typedef struct packed {
        logic   valid;
        addr_t  addr;
        mdata_t mdata;
    } c0_req_t;

    // Read response, steered by the reserved metadata bit
    typedef struct packed {
        logic   valid;
        mdata_t mdata;
        line_t  data;
    } c0_rsp_t;

    // Write request from the accelerator
    // The len field holds the beat count minus one
    typedef struct packed {
        logic      valid;
        addr_t     addr;
        cl_num_t   len;
        heap_idx_t idx;
    } c1_req_t;

    // One write beat on the memory port, with its data taken from the heap
    typedef struct packed {
        logic  valid;
        logic  sop;
        addr_t addr;
        line_t data;
    } c1_tx_t;

    // Write data pushed into the heap ahead of its request
    typedef struct packed {
        logic      en;
        heap_idx_t idx;
        cl_num_t   cl_num;
        line_t     data;
    } heap_wr_t;

endpackage

//--- edge_macros.svh
// Size definitions shared by the memory edge package, its RTL and its testbench
`ifndef EDGE_MACROS_SVH
`define EDGE_MACROS_SVH

// ====================
// Data and address widths
// ====================

// Width of one data line moved by a single memory-port beat
`define LINE_BITS 64

// Width of a line address on both request channels
`define ADDR_BITS 32

// Width of the read request metadata that comes back with the response
`define MDATA_BITS 16

// Metadata bit reserved for page-table walker reads
// Accelerator reads always leave this bit clear
`define RESERVED_MDATA_IDX 15

// ====================
// Write heap sizing
// ====================

// Number of heap slots handed out by the accelerator edge
`define HEAP_ENTRIES 16

// Largest multi-line write, in beats
`define MAX_BEATS 4

`endif
